// File: stm_params_pkg.sv
package stm_params_pkg;

  // ************************************************************************
  // Sequencer sizes
  // ************************************************************************

  // Pattern segments, one playing while the other is loaded
  localparam int NUM_SEGMENT = 2;

  localparam int IDX_W = 4;

  // Pattern table length per segment
  localparam int MAX_CYCLE = 1 << IDX_W;

  // Prescaler width per segment
  localparam int DIV_W = 16;

  // ************************************************************************
  // Repeat control
  // ************************************************************************

  // Repeat count that never raises stop
  localparam logic [15:0] REP_INFINITE = 16'hffff;

endpackage

// File: stm_types_pkg.sv
package stm_types_pkg;

  // ************************************************************************
  // Segment switch rules
  // ************************************************************************

  // Immediate switch, switch at index wrap, or switch on a GPIO rising edge
  typedef enum logic [1:0] {
    IMMEDIATE = 2'd0,
    SYNC_IDX  = 2'd1,
    GPIO_RISE = 2'd2
  } transition_mode_t;

  // ************************************************************************
  // Data fields
  // ************************************************************************

  // Pattern index within a segment table
  typedef logic [stm_params_pkg::IDX_W-1:0] idx_t;

  // Intensity or phase of one transducer
  typedef logic [7:0] drive_t;

endpackage

// File: stm_timer.sv
`timescale 1ns/1ns

module stm_timer (
  input  logic                                 CLK,
  input  logic                                 rst_n,
  input  logic                                 update_settings,
  input  logic [stm_params_pkg::IDX_W:0]       cycle [stm_params_pkg::NUM_SEGMENT],
  input  logic [stm_params_pkg::DIV_W-1:0]     freq_div [stm_params_pkg::NUM_SEGMENT],
  output stm_types_pkg::idx_t                  idx_seg [stm_params_pkg::NUM_SEGMENT],
  output logic                                 wrap [stm_params_pkg::NUM_SEGMENT]
);

  logic                             running;
  logic [stm_params_pkg::DIV_W-1:0] presc [stm_params_pkg::NUM_SEGMENT];

  // Counters stay idle until the first settings update
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      running <= 1'b0;
    end else if (update_settings) begin
      running <= 1'b1;
    end
  end

  for (genvar s = 0; s < stm_params_pkg::NUM_SEGMENT; s++) begin : g_seg
    logic tick;
    logic last;

    // End of one freq_div period
    assign tick = running && (presc[s] == freq_div[s] - 1'b1);
    assign last = ({1'b0, idx_seg[s]} == cycle[s] - 1'b1);

    always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
        presc[s]   <= '0;
        idx_seg[s] <= '0;
        wrap[s]    <= 1'b0;
      end else if (update_settings) begin
        presc[s]   <= '0;
        idx_seg[s] <= '0;
        wrap[s]    <= 1'b0;
      end else begin
        // wrap marks the cycle in which the index shows 0 again
        wrap[s] <= tick && last;
        if (tick) begin
          presc[s]   <= '0;
          idx_seg[s] <= last ? '0 : idx_seg[s] + 1'b1;
        end else if (running) begin
          presc[s] <= presc[s] + 1'b1;
        end
      end
    end

    a_freq_div_nonzero : assert property (
      @(posedge CLK) disable iff (!rst_n)
      update_settings |-> freq_div[s] != '0
    );
  end

endmodule

// File: stm_swapchain.sv
`timescale 1ns/1ns

module stm_swapchain (
  input  logic                             CLK,
  input  logic                             rst_n,
  input  logic                             update_settings,
  input  logic                             req_segment,
  input  stm_types_pkg::transition_mode_t  transition_mode,
  input  logic [1:0]                       transition_value,
  input  logic [15:0]                      rep [stm_params_pkg::NUM_SEGMENT],
  input  logic                             gpio_in [4],
  input  stm_types_pkg::idx_t              idx_seg [stm_params_pkg::NUM_SEGMENT],
  input  logic                             wrap [stm_params_pkg::NUM_SEGMENT],
  output logic                             segment,
  output stm_types_pkg::idx_t              idx,
  output logic                             stop
);

  logic                            pending;
  logic                            req_seg;
  stm_types_pkg::transition_mode_t mode_q;
  logic [1:0]                      gpio_sel;
  logic                            gpio_d [4];
  logic                            gpio_rise;
  logic                            do_switch;
  logic                            next_seg;
  logic [15:0]                     loop_cnt;

  assign gpio_rise = gpio_in[gpio_sel] && !gpio_d[gpio_sel];

  // ************************************************************************
  // Switch decision
  // ************************************************************************

  always_comb begin
    do_switch = 1'b0;
    next_seg  = req_seg;
    if (update_settings) begin
      // A new request overrides any pending one
      do_switch = (transition_mode == stm_types_pkg::IMMEDIATE);
      next_seg  = req_segment;
    end else if (pending) begin
      case (mode_q)
        stm_types_pkg::SYNC_IDX:  do_switch = wrap[req_seg];
        stm_types_pkg::GPIO_RISE: do_switch = gpio_rise;
        default:                  do_switch = 1'b1;
      endcase
    end
  end

  // ************************************************************************
  // Request, segment and loop state
  // ************************************************************************

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      pending  <= 1'b0;
      req_seg  <= 1'b0;
      mode_q   <= stm_types_pkg::IMMEDIATE;
      gpio_sel <= 2'd0;
      segment  <= 1'b0;
      loop_cnt <= 16'd0;
      stop     <= 1'b0;
      for (int i = 0; i < 4; i++) begin
        gpio_d[i] <= 1'b0;
      end
    end else begin
      for (int i = 0; i < 4; i++) begin
        gpio_d[i] <= gpio_in[i];
      end

      if (update_settings) begin
        pending  <= (transition_mode != stm_types_pkg::IMMEDIATE);
        req_seg  <= req_segment;
        mode_q   <= transition_mode;
        gpio_sel <= transition_value;
      end else if (do_switch) begin
        pending <= 1'b0;
      end

      if (do_switch) begin
        segment  <= next_seg;
        loop_cnt <= 16'd0;
        stop     <= 1'b0;
      end else if (wrap[segment] && !stop) begin
        loop_cnt <= loop_cnt + 16'd1;
        if (rep[segment] != stm_params_pkg::REP_INFINITE &&
            loop_cnt + 16'd1 == rep[segment]) begin
          stop <= 1'b1;
        end
      end
    end
  end

  // Index of whichever segment is playing
  assign idx = idx_seg[segment];

endmodule

// File: stm_gain.sv
`timescale 1ns/1ns

module stm_gain #(
  parameter int DEPTH = 249
) (
  input  logic                       CLK,
  input  logic                       rst_n,
  input  logic                       mem_we,
  input  logic                       mem_segment,
  input  stm_types_pkg::idx_t        mem_idx,
  input  logic [$clog2(DEPTH)-1:0]   mem_tr,
  input  stm_types_pkg::drive_t      mem_intensity,
  input  stm_types_pkg::drive_t      mem_phase,
  input  logic                       start,
  input  logic                       rd_segment,
  input  stm_types_pkg::idx_t        rd_idx,
  output logic                       busy,
  output stm_types_pkg::drive_t      intensity,
  output stm_types_pkg::drive_t      phase,
  output logic                       dout_valid,
  input  logic                       dout_ready
);

  localparam int TR_W     = $clog2(DEPTH);
  localparam int MEM_SIZE = stm_params_pkg::NUM_SEGMENT * stm_params_pkg::MAX_CYCLE * DEPTH;
  localparam int ADDR_W   = $clog2(MEM_SIZE);

  // Intensity in the upper byte, phase in the lower byte
  logic [15:0]       mem [MEM_SIZE];
  logic [ADDR_W-1:0] wr_addr;
  logic [ADDR_W-1:0] rd_base;
  logic [ADDR_W-1:0] rd_addr;
  logic [TR_W-1:0]   tr;
  logic              issuing;
  logic              ld;
  logic              take;

  // Entry order is segment, then index, then transducer
  assign wr_addr = ADDR_W'({mem_segment, mem_idx}) * ADDR_W'(DEPTH) + ADDR_W'(mem_tr);
  assign rd_addr = rd_base + ADDR_W'(tr);

  assign take = dout_valid && dout_ready;
  // Read only when the output register is empty or being emptied
  assign ld = issuing && (!dout_valid || dout_ready);

  always_ff @(posedge CLK) begin
    if (mem_we) begin
      mem[wr_addr] <= {mem_intensity, mem_phase};
    end
  end

  // Registered read straight into the output pair
  always_ff @(posedge CLK) begin
    if (ld) begin
      {intensity, phase} <= mem[rd_addr];
    end
  end

  always_ff @(posedge CLK) begin
    if (start) begin
      rd_base <= ADDR_W'({rd_segment, rd_idx}) * ADDR_W'(DEPTH);
    end
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      issuing    <= 1'b0;
      tr         <= '0;
      dout_valid <= 1'b0;
    end else begin
      if (start) begin
        busy    <= 1'b1;
        issuing <= 1'b1;
        tr      <= '0;
      end else begin
        if (ld) begin
          if (tr == TR_W'(DEPTH - 1)) begin
            issuing <= 1'b0;
          end else begin
            tr <= tr + 1'b1;
          end
        end
        // Last pair leaves once nothing is left to read
        if (take && !issuing) begin
          busy <= 1'b0;
        end
      end

      if (ld) begin
        dout_valid <= 1'b1;
      end else if (take) begin
        dout_valid <= 1'b0;
      end
    end
  end

  a_hold_under_stall : assert property (
    @(posedge CLK) disable iff (!rst_n)
    dout_valid && !dout_ready |=> dout_valid && $stable(intensity) && $stable(phase)
  );

endmodule

// File: stm_ctrl.sv
`timescale 1ns/1ns

module stm_ctrl #(
  parameter int DEPTH = 249
) (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  logic                  update,
  input  logic                  segment,
  input  stm_types_pkg::idx_t   idx,
  input  logic                  stop,
  input  logic                  busy,
  output logic                  start,
  output logic                  rd_segment,
  output stm_types_pkg::idx_t   rd_idx,
  output logic                  overrun
);

  logic        idle;
  logic [31:0] busy_len;

  // start is high one cycle before busy rises
  assign idle = !busy && !start;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      start      <= 1'b0;
      rd_segment <= 1'b0;
      rd_idx     <= '0;
      overrun    <= 1'b0;
    end else begin
      start <= update && idle;

      // Stopped playback keeps the last frozen pattern
      if (update && !stop) begin
        rd_segment <= segment;
        rd_idx     <= idx;
      end

      if (update && !idle) begin
        overrun <= 1'b1;
      end
    end
  end

  // ************************************************************************
  // Readout length tracking
  // ************************************************************************

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      busy_len <= 32'd0;
    end else if (start) begin
      busy_len <= 32'd0;
    end else if (busy) begin
      busy_len <= busy_len + 32'd1;
    end
  end

  a_no_start_while_busy : assert property (
    @(posedge CLK) disable iff (!rst_n)
    start |-> !busy
  );

  // One issue cycle plus one cycle per transducer at least
  a_full_stream : assert property (
    @(posedge CLK) disable iff (!rst_n)
    $fell(busy) |-> busy_len >= 32'(DEPTH + 1)
  );

endmodule

// File: stm.sv
`timescale 1ns/1ns

module stm #(
  parameter int DEPTH = 249
) (
  input  logic                             CLK,
  input  logic                             rst_n,
  input  logic                             update_settings,
  input  logic [stm_params_pkg::IDX_W:0]   cycle [stm_params_pkg::NUM_SEGMENT],
  input  logic [stm_params_pkg::DIV_W-1:0] freq_div [stm_params_pkg::NUM_SEGMENT],
  input  logic [15:0]                      rep [stm_params_pkg::NUM_SEGMENT],
  input  logic                             req_segment,
  input  stm_types_pkg::transition_mode_t  transition_mode,
  input  logic [1:0]                       transition_value,
  input  logic                             update,
  input  logic                             gpio_in [4],
  input  logic                             mem_we,
  input  logic                             mem_segment,
  input  stm_types_pkg::idx_t              mem_idx,
  input  logic [$clog2(DEPTH)-1:0]         mem_tr,
  input  stm_types_pkg::drive_t            mem_intensity,
  input  stm_types_pkg::drive_t            mem_phase,
  output stm_types_pkg::drive_t            intensity,
  output stm_types_pkg::drive_t            phase,
  output logic                             dout_valid,
  input  logic                             dout_ready,
  output logic                             overrun,
  output logic                             segment,
  output stm_types_pkg::idx_t              idx
);

  stm_types_pkg::idx_t idx_seg [stm_params_pkg::NUM_SEGMENT];
  logic                wrap [stm_params_pkg::NUM_SEGMENT];
  logic                stop;
  logic                start;
  logic                rd_segment;
  stm_types_pkg::idx_t rd_idx;
  logic                busy;

  // ************************************************************************
  // Sequencing
  // ************************************************************************

  stm_timer timer_inst (
    .CLK             (CLK),
    .rst_n           (rst_n),
    .update_settings (update_settings),
    .cycle           (cycle),
    .freq_div        (freq_div),
    .idx_seg         (idx_seg),
    .wrap            (wrap)
  );

  stm_swapchain swapchain_inst (
    .CLK              (CLK),
    .rst_n            (rst_n),
    .update_settings  (update_settings),
    .req_segment      (req_segment),
    .transition_mode  (transition_mode),
    .transition_value (transition_value),
    .rep              (rep),
    .gpio_in          (gpio_in),
    .idx_seg          (idx_seg),
    .wrap             (wrap),
    .segment          (segment),
    .idx              (idx),
    .stop             (stop)
  );

  // ************************************************************************
  // Readout
  // ************************************************************************

  stm_ctrl #(
    .DEPTH (DEPTH)
  ) ctrl_inst (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .update     (update),
    .segment    (segment),
    .idx        (idx),
    .stop       (stop),
    .busy       (busy),
    .start      (start),
    .rd_segment (rd_segment),
    .rd_idx     (rd_idx),
    .overrun    (overrun)
  );

  stm_gain #(
    .DEPTH (DEPTH)
  ) gain_inst (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .mem_we        (mem_we),
    .mem_segment   (mem_segment),
    .mem_idx       (mem_idx),
    .mem_tr        (mem_tr),
    .mem_intensity (mem_intensity),
    .mem_phase     (mem_phase),
    .start         (start),
    .rd_segment    (rd_segment),
    .rd_idx        (rd_idx),
    .busy          (busy),
    .intensity     (intensity),
    .phase         (phase),
    .dout_valid    (dout_valid),
    .dout_ready    (dout_ready)
  );

endmodule

// File: tb_stm_vectors.svh
`ifndef TB_STM_VECTORS_SVH
`define TB_STM_VECTORS_SVH

// Row columns cycle0 cycle1 div0 div1 rep0 rep1 | req mode gpio_sel | pre_clocks pre_seg
//          gpio_pin wait_clocks rand_ready overrun | exp_seg exp_idx rd_seg rd_idx
// Mode 0 is immediate, 1 sync to index wrap, 2 gpio rise, and gpio_pin -1 raises no pin

localparam int NUM_ROWS  = 10;
localparam int NUM_COLS  = 19;

localparam int C_C0      = 0;
localparam int C_C1      = 1;
localparam int C_D0      = 2;
localparam int C_D1      = 3;
localparam int C_R0      = 4;
localparam int C_R1      = 5;
localparam int C_REQ     = 6;
localparam int C_MODE    = 7;
localparam int C_TVAL    = 8;
localparam int C_PRE     = 9;
localparam int C_PRE_SEG = 10;
localparam int C_GPIO    = 11;
localparam int C_WAIT    = 12;
localparam int C_RAND    = 13;
localparam int C_OVR     = 14;
localparam int C_SEG     = 15;
localparam int C_IDX     = 16;
localparam int C_RD_SEG  = 17;
localparam int C_RD_IDX  = 18;

int vec [NUM_ROWS][NUM_COLS] = '{
  '{8, 8,  3, 2, 65535, 65535, 0, 0, 0, 0, 0, -1, 10, 0, 0, 0, 3, 0, 3},
  '{8, 5,  3, 2, 65535, 65535, 1, 0, 0, 0, 1, -1, 13, 1, 0, 1, 1, 1, 1},
  // Segment 0 wraps after 8 clocks, switch lands one clock later
  '{4, 5,  2, 2, 65535, 65535, 0, 1, 0, 8, 1, -1,  1, 0, 0, 0, 0, 0, 0},
  // Segment 1 wraps after 6 clocks, the GPIO edge alone may switch
  '{4, 6,  2, 1, 65535, 65535, 1, 2, 2, 7, 0,  2,  3, 1, 0, 1, 4, 1, 4},
  // Single repeat, stop rises after the first wrap
  '{4, 6,  2, 1,     1, 65535, 0, 0, 0, 0, 0, -1,  3, 0, 0, 0, 1, 0, 1},
  '{4, 6,  2, 1,     1, 65535, 0, 1, 0, 0, 0, -1,  5, 1, 0, 0, 2, 0, 1},
  '{4, 2,  2, 1, 65535, 65535, 1, 0, 0, 0, 1, -1,  7, 0, 0, 1, 1, 1, 1},
  '{4, 2,  2, 1, 65535, 65535, 1, 1, 0, 0, 1, -1,  4, 1, 0, 1, 0, 1, 0},
  '{8, 2,  1, 1, 65535, 65535, 0, 0, 0, 0, 0, -1, 11, 1, 1, 0, 3, 0, 3},
  '{8, 16, 1, 3, 65535, 65535, 1, 0, 0, 0, 1, -1, 20, 0, 0, 1, 6, 1, 6}
};

`endif

// File: tb_stm.sv
`timescale 1ns/1ns

module tb_stm;

  localparam int DEPTH        = 6;
  localparam int TR_W         = $clog2(DEPTH);
  localparam int NSEG         = stm_params_pkg::NUM_SEGMENT;
  localparam int STREAM_LIMIT = 200;
  localparam int IDLE_LIMIT   = 20;

  `include "tb_stm_vectors.svh"

  logic                              CLK;
  logic                              rst_n;
  logic                              update_settings;
  logic [stm_params_pkg::IDX_W:0]    cycle [NSEG];
  logic [stm_params_pkg::DIV_W-1:0]  freq_div [NSEG];
  logic [15:0]                       rep [NSEG];
  logic                              req_segment;
  stm_types_pkg::transition_mode_t   transition_mode;
  logic [1:0]                        transition_value;
  logic                              update;
  logic                              gpio_in [4];
  logic                              mem_we;
  logic                              mem_segment;
  stm_types_pkg::idx_t               mem_idx;
  logic [TR_W-1:0]                   mem_tr;
  stm_types_pkg::drive_t             mem_intensity;
  stm_types_pkg::drive_t             mem_phase;
  stm_types_pkg::drive_t             intensity;
  stm_types_pkg::drive_t             phase;
  logic                              dout_valid;
  logic                              dout_ready;
  logic                              overrun;
  logic                              segment;
  stm_types_pkg::idx_t               idx;

  integer seed;
  int     errors;
  int     row_errors;
  int     rows_failed;
  logic   ovr_seen;
  logic   timed_out;

  stm #(
    .DEPTH (DEPTH)
  ) stm_inst (
    .CLK (CLK), .rst_n (rst_n), .update_settings (update_settings),
    .cycle (cycle), .freq_div (freq_div), .rep (rep),
    .req_segment (req_segment), .transition_mode (transition_mode),
    .transition_value (transition_value), .update (update), .gpio_in (gpio_in),
    .mem_we (mem_we), .mem_segment (mem_segment), .mem_idx (mem_idx), .mem_tr (mem_tr),
    .mem_intensity (mem_intensity), .mem_phase (mem_phase),
    .intensity (intensity), .phase (phase), .dout_valid (dout_valid),
    .dout_ready (dout_ready), .overrun (overrun), .segment (segment), .idx (idx)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // Pattern fill that depends on every bit of segment, index and transducer
  function automatic logic [7:0] pattern_intensity(input int seg, input int ix, input int tr);
    return {seg[0], ix[3:0], tr[2:0]};
  endfunction

  function automatic logic [7:0] pattern_phase(input int seg, input int ix, input int tr);
    return 8'((seg * 16 + ix) * 7 + tr * 13 + 3);
  endfunction

  task automatic step_clock;
    @(posedge CLK);
    #10;
  endtask

  task automatic load_memory;
    mem_we = 1'b1;
    for (int s = 0; s < NSEG; s++) begin
      for (int i = 0; i < stm_params_pkg::MAX_CYCLE; i++) begin
        for (int t = 0; t < DEPTH; t++) begin
          mem_segment   = 1'(s);
          mem_idx       = stm_types_pkg::idx_t'(i);
          mem_tr        = TR_W'(t);
          mem_intensity = pattern_intensity(s, i, t);
          mem_phase     = pattern_phase(s, i, t);
          step_clock();
        end
      end
    end
    mem_we = 1'b0;
  endtask

  // ************************************************************************
  // One UPDATE and its stream
  // ************************************************************************

  task automatic run_stream(input int rand_rdy, input int ovr, input int rd_seg, input int rd_ix);
    int   pairs;
    int   waited;
    logic injected;
    pairs    = 0;
    waited   = 0;
    injected = 1'b0;
    update = 1'b1;
    step_clock();
    update = 1'b0;
    while (pairs < DEPTH) begin
      if (waited == STREAM_LIMIT) begin
        $display("Stream did not deliver all transducer pairs in time at time %0t", $time);
        timed_out = 1'b1;
        return;
      end
      dout_ready = (rand_rdy != 0) ? 1'($random(seed)) : 1'b1;
      if (dout_valid && dout_ready) begin
        if (intensity !== pattern_intensity(rd_seg, rd_ix, pairs) ||
            phase !== pattern_phase(rd_seg, rd_ix, pairs)) begin
          $display("ERROR %0t: pair %0d got %h/%h, expected %h/%h", $time, pairs,
                   intensity, phase, pattern_intensity(rd_seg, rd_ix, pairs),
                   pattern_phase(rd_seg, rd_ix, pairs));
          errors++;
          row_errors++;
        end
        pairs++;
      end
      // A second UPDATE while the reader is busy
      if (ovr != 0 && dout_valid && !injected) begin
        update   = 1'b1;
        injected = 1'b1;
      end
      step_clock();
      update = 1'b0;
      waited++;
    end
    dout_ready = 1'b1;
    waited = 0;
    while (stm_inst.gain_inst.busy) begin
      if (waited == IDLE_LIMIT) begin
        $display("Gain reader stayed busy after the last pair at time %0t", $time);
        timed_out = 1'b1;
        return;
      end
      step_clock();
      waited++;
    end
    repeat (4) begin
      if (dout_valid) begin
        $display("ERROR %0t: extra pair after a complete stream", $time);
        errors++;
        row_errors++;
      end
      step_clock();
    end
  endtask

  initial begin
    seed             = 32'h2532eebe;
    errors           = 0;
    rows_failed      = 0;
    ovr_seen         = 1'b0;
    timed_out        = 1'b0;
    rst_n            = 1'b0;
    update_settings  = 1'b0;
    req_segment      = 1'b0;
    transition_mode  = stm_types_pkg::IMMEDIATE;
    transition_value = 2'd0;
    update           = 1'b0;
    mem_we           = 1'b0;
    mem_segment      = 1'b0;
    mem_idx          = '0;
    mem_tr           = '0;
    mem_intensity    = '0;
    mem_phase        = '0;
    dout_ready       = 1'b1;
    for (int i = 0; i < 4; i++) begin
      gpio_in[i] = 1'b0;
    end
    for (int s = 0; s < NSEG; s++) begin
      cycle[s]    = '0;
      freq_div[s] = 16'd1;
      rep[s]      = 16'hffff;
    end
    repeat (2) @(posedge CLK);
    #10;
    rst_n = 1'b1;
    load_memory();

    for (int r = 0; r < NUM_ROWS; r++) begin
      row_errors = 0;
      for (int i = 0; i < 4; i++) begin
        gpio_in[i] = 1'b0;
      end
      cycle[0]         = 5'(vec[r][C_C0]);
      cycle[1]         = 5'(vec[r][C_C1]);
      freq_div[0]      = 16'(vec[r][C_D0]);
      freq_div[1]      = 16'(vec[r][C_D1]);
      rep[0]           = 16'(vec[r][C_R0]);
      rep[1]           = 16'(vec[r][C_R1]);
      req_segment      = 1'(vec[r][C_REQ]);
      transition_mode  = stm_types_pkg::transition_mode_t'(2'(vec[r][C_MODE]));
      transition_value = 2'(vec[r][C_TVAL]);
      update_settings  = 1'b1;
      step_clock();
      update_settings  = 1'b0;

      repeat (vec[r][C_PRE]) step_clock();
      if (segment !== 1'(vec[r][C_PRE_SEG])) begin
        $display("ERROR %0t: segment %0d before the switch event, expected %0d",
                 $time, segment, vec[r][C_PRE_SEG]);
        errors++;
        row_errors++;
      end
      if (vec[r][C_GPIO] >= 0) begin
        gpio_in[vec[r][C_GPIO]] = 1'b1;
      end
      repeat (vec[r][C_WAIT]) step_clock();
      if (segment !== 1'(vec[r][C_SEG]) || idx !== stm_types_pkg::idx_t'(vec[r][C_IDX])) begin
        $display("ERROR %0t: segment/idx %0d/%0d, expected %0d/%0d", $time, segment, idx,
                 vec[r][C_SEG], vec[r][C_IDX]);
        errors++;
        row_errors++;
      end

      run_stream(vec[r][C_RAND], vec[r][C_OVR], vec[r][C_RD_SEG], vec[r][C_RD_IDX]);
      if (timed_out) begin
        break;
      end
      ovr_seen = ovr_seen | (vec[r][C_OVR] != 0);
      if (overrun !== ovr_seen) begin
        $display("ERROR %0t: overrun %0b, expected %0b", $time, overrun, ovr_seen);
        errors++;
        row_errors++;
      end

      if (row_errors != 0) begin
        rows_failed++;
      end
      $display("row %0d: %s (%0d errors)", r, (row_errors == 0) ? "ok" : "failed", row_errors);
    end

    $display("rows run %0d, rows failed %0d, errors %0d", NUM_ROWS, rows_failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+.
stm_params_pkg.sv
stm_types_pkg.sv
stm_timer.sv
stm_swapchain.sv
stm_gain.sv
stm_ctrl.sv
stm.sv
tb_stm.sv

// File: run.sh
#!/bin/sh
# Build with Verilator and run the testbench; status follows the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module tb_stm -f project.f -o sim_tb_stm &&
./obj_dir/sim_tb_stm | tee /dev/stderr | grep -q "=== PASS ===" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
